// ==== vlog.f ====
+incdir+common
common/elem_pkg.sv
common/lane_pkg.sv
common/vfu_op_if.sv
lane/lane_sequencer.sv
lane/lane_alu.sv
lane/lane_vrf.sv
source/vector_lane.sv
verif/vector_lane_chk.sv
verif/vector_lane_tb.sv

// ==== Makefile ====
# Verilator build and run of the vector lane testbench

TOP := vector_lane_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir

// ==== verif/vector_lane_tb.sv ====
// Directed testbench for one vector lane; checks register results against a lane model
`timescale 1ns/10ps
`default_nettype none

`include "lane_defs.svh"

module vector_lane_tb import lane_pkg::*; import elem_pkg::*; ();

  localparam int LANE_ID = 1;
  // All tests take roughly 470 cycles
  localparam int TIMEOUT_CYCLES = 2000;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  vinsn_id_t   req_id;
  alu_op_e     req_op;
  sew_e        req_sew;
  vl_t         req_vl;
  vreg_t       req_vs1, req_vs2, req_vd;
  vinsn_vec_t  vinsn_done, vinsn_running;
  logic        host_we;
  vreg_t       host_reg;
  vword_idx_t  host_word;
  logic [63:0] host_wdata, host_rdata;

  // Expected register contents of this lane
  logic [63:0] model [`NR_VREGS][`VREG_WORDS];
  // IDs in the order their done pulses were seen
  vinsn_id_t   done_log[$];
  int          seed = 47354;
  int          cycles = 0;
  int          errors = 0;

  vector_lane #(.LaneId(LANE_ID)) vector_lane_inst (
    .clk_i (clk), .rst_ni (rst_n),
    .req_valid_i (req_valid), .req_ready_o (req_ready), .req_id_i (req_id),
    .req_op_i (req_op), .req_sew_i (req_sew), .req_vl_i (req_vl),
    .req_vs1_i (req_vs1), .req_vs2_i (req_vs2), .req_vd_i (req_vd),
    .vinsn_done_o (vinsn_done), .vinsn_running_o (vinsn_running),
    .host_we_i (host_we), .host_reg_i (host_reg), .host_word_i (host_word),
    .host_wdata_i (host_wdata), .host_rdata_o (host_rdata)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $fatal(1, "simulation stopped on timeout");
    end
  end

  // Done is a register output, sampled away from the rising edge
  always @(negedge clk) begin
    for (int i = 0; i < `NR_VINSN; i++) begin
      if (vinsn_done[i]) done_log.push_back(vinsn_id_t'(i));
    end
  end

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Regression failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic host_write(input vreg_t r, input vword_idx_t w, input logic [63:0] data);
    host_we    = 1'b1;
    host_reg   = r;
    host_word  = w;
    host_wdata = data;
    next_cycle();
    host_we    = 1'b0;
    model[r][w] = data;
  endtask

  // Registered read, data valid after the next edge
  task automatic host_read(input vreg_t r, input vword_idx_t w, output logic [63:0] data);
    host_reg  = r;
    host_word = w;
    next_cycle();
    data = host_rdata;
  endtask

  task automatic fill_reg(input vreg_t r);
    for (int w = 0; w < `VREG_WORDS; w++) begin
      host_write(r, vword_idx_t'(w), {$random(seed), $random(seed)});
    end
  endtask

  task automatic check_reg(input vreg_t r);
    logic [63:0] data;
    for (int w = 0; w < `VREG_WORDS; w++) begin
      host_read(r, vword_idx_t'(w), data);
      check_equal(data, model[r][w], $sformatf("v%0d word %0d", r, w));
    end
  endtask

  // Lane share of vl, then vd = vs2 op vs1 per element with wrap-around
  task automatic model_exec(input alu_op_e op, input sew_e sew, input vl_t vl,
                            input vreg_t vs1, input vreg_t vs2, input vreg_t vd);
    int          lane_vl;
    int          ebytes;
    int          epw;
    int          sh;
    vword_idx_t  wi;
    logic [63:0] mask, a, b, r;
    lane_vl = int'(vl) / `NR_LANES;
    if (LANE_ID < int'(vl) % `NR_LANES) lane_vl++;
    ebytes = 1 << int'(sew);
    epw    = 8 / ebytes;
    mask   = (ebytes == 8) ? '1 : ((64'd1 << (ebytes * 8)) - 64'd1);
    for (int e = 0; e < lane_vl; e++) begin
      wi = vword_idx_t'(e / epw);
      sh = (e % epw) * ebytes * 8;
      a  = (model[vs2][wi] >> sh) & mask;
      b  = (model[vs1][wi] >> sh) & mask;
      case (op)
        ALU_ADD: r = a + b;
        ALU_SUB: r = a - b;
        ALU_AND: r = a & b;
        ALU_OR:  r = a | b;
        default: r = a ^ b;
      endcase
      // Bytes outside the element keep their value
      model[vd][wi] = (model[vd][wi] & ~(mask << sh)) | ((r & mask) << sh);
    end
  endtask

  // Holds the request until accepted, reports stalled cycles
  task automatic issue(input vinsn_id_t id, input alu_op_e op, input sew_e sew, input vl_t vl,
                       input vreg_t vs1, input vreg_t vs2, input vreg_t vd, output int waited);
    req_valid = 1'b1;
    req_id    = id;
    req_op    = op;
    req_sew   = sew;
    req_vl    = vl;
    req_vs1   = vs1;
    req_vs2   = vs2;
    req_vd    = vd;
    waited    = 0;
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
      waited++;
    end
    next_cycle();
    req_valid = 1'b0;
    model_exec(op, sew, vl, vs1, vs2, vd);
  endtask

  // Next done in order must belong to id
  task automatic wait_done(input vinsn_id_t id);
    while (done_log.size() == 0) next_cycle();
    check_equal(64'(done_log.pop_front()), 64'(id), "done order");
  endtask

  task automatic test_reset();
    check_equal(64'(req_ready), 64'd1, "ready after reset");
    check_equal(64'(vinsn_running), 64'd0, "running after reset");
    check_equal(64'(vinsn_done), 64'd0, "done after reset");
    for (int r = 0; r < `NR_VREGS; r++) check_reg(vreg_t'(r));
  endtask

  task automatic test_ops_widths();
    int waited;
    int epw;
    for (int o = 0; o < 5; o++) begin
      fill_reg(3'd1);
      fill_reg(3'd2);
      for (int s = 0; s < 4; s++) begin
        // Three full words per lane
        epw = 8 >> s;
        issue(vinsn_id_t'(s), alu_op_e'(o), sew_e'(s), vl_t'(`NR_LANES * epw * 3),
              3'd1, 3'd2, 3'd3, waited);
        wait_done(vinsn_id_t'(s));
        check_reg(3'd3);
      end
    end
  endtask

  task automatic test_lane_split();
    int  waited;
    vl_t vls [5];
    // Remainders 0 to 3, then vl 1 which leaves lane 1 empty
    vls = '{8'd32, 8'd33, 8'd34, 8'd35, 8'd1};
    for (int i = 0; i < 5; i++) begin
      fill_reg(3'd4);
      issue(vinsn_id_t'(i), ALU_ADD, EW16, vls[i], 3'd1, 3'd2, 3'd4, waited);
      wait_done(vinsn_id_t'(i));
      check_reg(3'd4);
    end
  endtask

  task automatic test_completion();
    int waited;
    issue(2'd2, ALU_SUB, EW32, 8'd24, 3'd1, 3'd2, 3'd5, waited);
    check_equal(64'(vinsn_running), 64'h4, "running after issue");
    wait_done(2'd2);
    check_equal(64'(vinsn_running), 64'd0, "running after done");
    repeat (4) next_cycle();
    check_equal(64'(done_log.size()), 64'd0, "extra done pulses");
    check_reg(3'd5);
  endtask

  task automatic test_backpressure();
    int waited;
    // Second one reads the first one's result
    issue(2'd0, ALU_ADD, EW8, 8'd128, 3'd1, 3'd2, 3'd6, waited);
    issue(2'd1, ALU_XOR, EW16, 8'd64, 3'd6, 3'd1, 3'd7, waited);
    wait_done(2'd0);
    wait_done(2'd1);
    check_reg(3'd6);
    check_reg(3'd7);
    // Same ID must wait for its earlier instance
    issue(2'd3, ALU_SUB, EW64, 8'd16, 3'd2, 3'd1, 3'd5, waited);
    issue(2'd3, ALU_OR, EW32, 8'd32, 3'd5, 3'd2, 3'd6, waited);
    check_equal(64'(waited > 0), 64'd1, "same ID request stalled");
    check_equal(64'(done_log.size()), 64'd1, "first instance done before accept");
    wait_done(2'd3);
    wait_done(2'd3);
    check_reg(3'd5);
    check_reg(3'd6);
  endtask

  initial begin
    rst_n      = 1'b0;
    req_valid  = 1'b0;
    req_id     = '0;
    req_op     = ALU_ADD;
    req_sew    = EW8;
    req_vl     = '0;
    req_vs1    = '0;
    req_vs2    = '0;
    req_vd     = '0;
    host_we    = 1'b0;
    host_reg   = '0;
    host_word  = '0;
    host_wdata = '0;
    for (int r = 0; r < `NR_VREGS; r++) begin
      for (int w = 0; w < `VREG_WORDS; w++) model[r][w] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();

    test_reset();
    test_ops_widths();
    test_lane_split();
    test_completion();
    test_backpressure();

    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : vector_lane_tb

`default_nettype wire

// ==== verif/vector_lane_chk.sv ====
// Assertions on the lane's request and completion handshakes; bound into vector_lane
`timescale 1ns/10ps
`default_nettype none

module vector_lane_chk import lane_pkg::*; import elem_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       req_valid_i,
  input logic       req_ready_i,
  input vinsn_id_t  req_id_i,
  input alu_op_e    req_op_i,
  input sew_e       req_sew_i,
  input vl_t        req_vl_i,
  input vreg_t      req_vs1_i,
  input vreg_t      req_vs2_i,
  input vreg_t      req_vd_i,
  input vinsn_vec_t vinsn_done_i,
  input vinsn_vec_t vinsn_running_i,
  input logic       wr_en_i
);

  // Stalled request keeps valid and all its fields
  a_req_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && !req_ready_i |=> req_valid_i &&
    $stable({req_id_i, req_op_i, req_sew_i, req_vl_i, req_vs1_i, req_vs2_i, req_vd_i}))
    else $error("request changed while stalled");

  // Each done bit is a single-cycle pulse
  a_done_pulse : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (vinsn_done_i & $past(vinsn_done_i)) == '0)
    else $error("done bit held for more than one cycle");

  // Only IDs that were running may finish
  a_done_running : assert property (@(posedge clk_i) disable iff (!rst_ni)
    vinsn_done_i != '0 |-> (vinsn_done_i & ~$past(vinsn_running_i)) == '0)
    else $error("done for an ID that was not running");

  // ALU writes only belong to an instruction in flight
  a_write_owned : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_en_i |-> vinsn_running_i != '0)
    else $error("register write with no running instruction");

endmodule : vector_lane_chk

bind vector_lane vector_lane_chk vector_lane_chk_inst (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .req_valid_i     (req_valid_i),
  .req_ready_i     (req_ready_o),
  .req_id_i        (req_id_i),
  .req_op_i        (req_op_i),
  .req_sew_i       (req_sew_i),
  .req_vl_i        (req_vl_i),
  .req_vs1_i       (req_vs1_i),
  .req_vs2_i       (req_vs2_i),
  .req_vd_i        (req_vd_i),
  .vinsn_done_i    (vinsn_done_o),
  .vinsn_running_i (vinsn_running_o),
  .wr_en_i         (alu_wr_en)
);

`default_nettype wire

// ==== source/vector_lane.sv ====
// Top level of one vector lane; joins decode, execute and register file behind plain ports
`timescale 1ns/10ps
`default_nettype none

module vector_lane import lane_pkg::*; import elem_pkg::*; #(
  parameter int unsigned LaneId = 1
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Request port
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  vinsn_id_t   req_id_i,
  input  alu_op_e     req_op_i,
  input  sew_e        req_sew_i,
  input  vl_t         req_vl_i,
  input  vreg_t       req_vs1_i,
  input  vreg_t       req_vs2_i,
  input  vreg_t       req_vd_i,
  // Completion and status
  output vinsn_vec_t  vinsn_done_o,
  output vinsn_vec_t  vinsn_running_o,
  // Host port
  input  logic        host_we_i,
  input  vreg_t       host_reg_i,
  input  vword_idx_t  host_word_i,
  input  logic [63:0] host_wdata_i,
  output logic [63:0] host_rdata_o
);

  // Sequencer to ALU
  vfu_op_if   vfu_op ();
  vinsn_vec_t alu_done;

  // ALU to register file
  vreg_t       alu_rd_reg_a;
  vreg_t       alu_rd_reg_b;
  vword_idx_t  alu_rd_word;
  logic [63:0] alu_rd_data_a;
  logic [63:0] alu_rd_data_b;
  logic        alu_wr_en;
  vreg_t       alu_wr_reg;
  vword_idx_t  alu_wr_word;
  logic [7:0]  alu_wr_be;
  logic [63:0] alu_wr_data;

  lane_sequencer #(
    .LaneId (LaneId)
  ) lane_sequencer_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_id_i        (req_id_i),
    .req_op_i        (req_op_i),
    .req_sew_i       (req_sew_i),
    .req_vl_i        (req_vl_i),
    .req_vs1_i       (req_vs1_i),
    .req_vs2_i       (req_vs2_i),
    .req_vd_i        (req_vd_i),
    .vinsn_done_i    (alu_done),
    .vinsn_done_o    (vinsn_done_o),
    .vinsn_running_o (vinsn_running_o),
    .op_o            (vfu_op)
  );

  lane_alu lane_alu_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .op_i         (vfu_op),
    .rd_reg_a_o   (alu_rd_reg_a),
    .rd_reg_b_o   (alu_rd_reg_b),
    .rd_word_o    (alu_rd_word),
    .rd_data_a_i  (alu_rd_data_a),
    .rd_data_b_i  (alu_rd_data_b),
    .wr_en_o      (alu_wr_en),
    .wr_reg_o     (alu_wr_reg),
    .wr_word_o    (alu_wr_word),
    .wr_be_o      (alu_wr_be),
    .wr_data_o    (alu_wr_data),
    .vinsn_done_o (alu_done)
  );

  lane_vrf lane_vrf_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_reg_a_i   (alu_rd_reg_a),
    .rd_reg_b_i   (alu_rd_reg_b),
    .rd_word_i    (alu_rd_word),
    .rd_data_a_o  (alu_rd_data_a),
    .rd_data_b_o  (alu_rd_data_b),
    .wr_en_i      (alu_wr_en),
    .wr_reg_i     (alu_wr_reg),
    .wr_word_i    (alu_wr_word),
    .wr_be_i      (alu_wr_be),
    .wr_data_i    (alu_wr_data),
    .host_we_i    (host_we_i),
    .host_reg_i   (host_reg_i),
    .host_word_i  (host_word_i),
    .host_wdata_i (host_wdata_i),
    .host_rdata_o (host_rdata_o)
  );

endmodule : vector_lane

`default_nettype wire

// ==== lane/lane_vrf.sv ====
// Result stage of one lane; vector register file with ALU ports and a host access port
`timescale 1ns/10ps
`default_nettype none

`include "lane_defs.svh"

module lane_vrf import lane_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // ALU read ports, combinational
  input  vreg_t       rd_reg_a_i,
  input  vreg_t       rd_reg_b_i,
  input  vword_idx_t  rd_word_i,
  output logic [63:0] rd_data_a_o,
  output logic [63:0] rd_data_b_o,
  // ALU write port with byte enables
  input  logic        wr_en_i,
  input  vreg_t       wr_reg_i,
  input  vword_idx_t  wr_word_i,
  input  logic [7:0]  wr_be_i,
  input  logic [63:0] wr_data_i,
  // Host port, registered read
  input  logic        host_we_i,
  input  vreg_t       host_reg_i,
  input  vword_idx_t  host_word_i,
  input  logic [63:0] host_wdata_i,
  output logic [63:0] host_rdata_o
);

  // Registers by words
  logic [63:0] mem_q [`NR_VREGS][`VREG_WORDS];
  logic [63:0] host_rdata_q;

  assign rd_data_a_o  = mem_q[rd_reg_a_i][rd_word_i];
  assign rd_data_b_o  = mem_q[rd_reg_b_i][rd_word_i];
  assign host_rdata_o = host_rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_mem_ff
    if (!rst_ni) begin
      for (int r = 0; r < `NR_VREGS; r++) begin
        for (int w = 0; w < `VREG_WORDS; w++) begin
          mem_q[r][w] <= '0;
        end
      end
      host_rdata_q <= '0;
    end else begin
      // ALU write first, host write only in a free cycle
      if (wr_en_i) begin
        for (int b = 0; b < 8; b++) begin
          if (wr_be_i[b]) begin
            mem_q[wr_reg_i][wr_word_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
          end
        end
      end else if (host_we_i) begin
        mem_q[host_reg_i][host_word_i] <= host_wdata_i;
      end
      // Old word on a read that meets a write
      host_rdata_q <= mem_q[host_reg_i][host_word_i];
    end
  end : p_mem_ff

endmodule : lane_vrf

`default_nettype wire

// ==== lane/lane_alu.sv ====
// Execute stage of one lane; walks the register words of one operation and writes results back
`timescale 1ns/10ps
`default_nettype none

module lane_alu import lane_pkg::*; import elem_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Operation from the sequencer
  vfu_op_if.alu       op_i,
  // Register file read ports
  output vreg_t       rd_reg_a_o,
  output vreg_t       rd_reg_b_o,
  output vword_idx_t  rd_word_o,
  input  logic [63:0] rd_data_a_i,
  input  logic [63:0] rd_data_b_i,
  // Register file write port
  output logic        wr_en_o,
  output vreg_t       wr_reg_o,
  output vword_idx_t  wr_word_o,
  output logic [7:0]  wr_be_o,
  output logic [63:0] wr_data_o,
  // One-hot done, high with the last write
  output vinsn_vec_t  vinsn_done_o
);

  // Full-width element operation, callers keep the low bits
  // Low bits of a 64-bit sum or difference wrap like the narrow one
  function automatic logic [63:0] alu_elem(alu_op_e op, logic [63:0] x, logic [63:0] y);
    case (op)
      ALU_ADD: alu_elem = x + y;
      ALU_SUB: alu_elem = x - y;
      ALU_AND: alu_elem = x & y;
      ALU_OR:  alu_elem = x | y;
      ALU_XOR: alu_elem = x ^ y;
      default: alu_elem = '0;
    endcase
  endfunction

  // Latched operation and progress
  vfu_operation_t op_q;
  logic           busy_q;
  vword_idx_t     word_q;
  vl_t            elems_q;

  // Per-word decode
  logic [3:0] elems_per_word;
  logic       last_word;
  vl_t        last_bytes;
  vword_u     opa, opb, res;
  logic [63:0] elem;

  assign op_i.ready = !busy_q;

  // Operand a is vs1, operand b is vs2
  assign rd_reg_a_o = op_q.vs1;
  assign rd_reg_b_o = op_q.vs2;
  assign rd_word_o  = word_q;
  assign opa        = rd_data_a_i;
  assign opb        = rd_data_b_i;

  assign elems_per_word = 4'd8 >> op_q.sew;
  assign last_word      = busy_q && (elems_q <= vl_t'(elems_per_word));
  assign last_bytes     = elems_q << op_q.sew;

  // Zero lane vl finishes without a write
  assign wr_en_o      = busy_q && (elems_q != '0);
  assign wr_reg_o     = op_q.vd;
  assign wr_word_o    = word_q;
  assign wr_data_o    = res;
  assign vinsn_done_o = last_word ? (vinsn_vec_t'(1) << op_q.id) : '0;

  // Result is vs2 op vs1 at the current element width
  always_comb begin : p_compute
    res  = '0;
    elem = '0;
    case (op_q.sew)
      EW8: begin
        for (int i = 0; i < 8; i++) begin
          elem     = alu_elem(op_q.op, 64'(opb.b[i]), 64'(opa.b[i]));
          res.b[i] = elem[7:0];
        end
      end
      EW16: begin
        for (int i = 0; i < 4; i++) begin
          elem     = alu_elem(op_q.op, 64'(opb.h[i]), 64'(opa.h[i]));
          res.h[i] = elem[15:0];
        end
      end
      EW32: begin
        for (int i = 0; i < 2; i++) begin
          elem     = alu_elem(op_q.op, 64'(opb.w[i]), 64'(opa.w[i]));
          res.w[i] = elem[31:0];
        end
      end
      default: res.d = alu_elem(op_q.op, opb.d, opa.d);
    endcase
  end : p_compute

  // Partial last word only enables the bytes of valid elements
  always_comb begin : p_byte_enable
    wr_be_o = 8'hff;
    if (elems_q < vl_t'(elems_per_word)) begin
      for (int b = 0; b < 8; b++) begin
        wr_be_o[b] = vl_t'(b) < last_bytes;
      end
    end
  end : p_byte_enable

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      word_q  <= '0;
      elems_q <= '0;
    end else if (!busy_q) begin
      if (op_i.valid) begin
        busy_q  <= 1'b1;
        word_q  <= '0;
        elems_q <= op_i.op.vl;
      end
    end else if (last_word) begin
      busy_q <= 1'b0;
    end else begin
      word_q  <= word_q + 1'b1;
      elems_q <= elems_q - vl_t'(elems_per_word);
    end
  end : p_ctrl_ff

  always_ff @(posedge clk_i) begin : p_op_ff
    if (op_i.valid && op_i.ready) begin
      op_q <= op_i.op;
    end
  end : p_op_ff

endmodule : lane_alu

`default_nettype wire

// ==== lane/lane_sequencer.sv ====
// Decode stage of one lane; accepts vector requests, tracks running IDs and feeds the ALU
`timescale 1ns/10ps
`default_nettype none

`include "lane_defs.svh"

module lane_sequencer import lane_pkg::*; import elem_pkg::*; #(
  parameter int unsigned LaneId = 0
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Request port from the main sequencer
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  vinsn_id_t  req_id_i,
  input  alu_op_e    req_op_i,
  input  sew_e       req_sew_i,
  input  vl_t        req_vl_i,
  input  vreg_t      req_vs1_i,
  input  vreg_t      req_vs2_i,
  input  vreg_t      req_vd_i,
  // Completion from the ALU
  input  vinsn_vec_t vinsn_done_i,
  // Completion and status to the main sequencer
  output vinsn_vec_t vinsn_done_o,
  output vinsn_vec_t vinsn_running_o,
  // Operation to the ALU
  vfu_op_if.seq      op_o
);

  // Running set and registered done pulses
  vinsn_vec_t running_d, running_q;
  vinsn_vec_t done_q;

  // Held operation
  vfu_operation_t op_q;
  vfu_operation_t op_new;
  logic           op_valid_d, op_valid_q;

  // Lane vl terms
  vl_t  vl_div;
  vl_t  vl_rem;
  logic vl_extra;
  vl_t  lane_vl;

  // Handshake terms
  logic op_stall;
  logic req_accept;

  assign vinsn_running_o = running_q;
  assign vinsn_done_o    = done_q;
  assign op_o.valid      = op_valid_q;
  assign op_o.op         = op_q;

  // Elements are interleaved over lanes
  // Lanes below the remainder get one extra element
  assign vl_div   = req_vl_i / vl_t'(`NR_LANES);
  assign vl_rem   = req_vl_i % vl_t'(`NR_LANES);
  assign vl_extra = vl_t'(LaneId) < vl_rem;
  assign lane_vl  = vl_div + vl_t'(vl_extra);

  // Held operation not yet taken by the ALU
  assign op_stall = op_valid_q && !op_o.ready;

  // Stall on a pending operation or on an ID still in flight
  assign req_ready_o = !op_stall && !running_q[req_id_i];
  assign req_accept  = req_valid_i && req_ready_o;

  // Operation built from the request
  assign op_new = '{
    id  : req_id_i,
    op  : req_op_i,
    sew : req_sew_i,
    vs1 : req_vs1_i,
    vs2 : req_vs2_i,
    vd  : req_vd_i,
    vl  : lane_vl
  };

  always_comb begin : p_sequencer
    // Done from the ALU retires the ID at the edge where vinsn_done_o rises
    running_d  = running_q & ~vinsn_done_i;
    op_valid_d = op_valid_q;

    // ALU took the operation
    if (op_valid_q && op_o.ready) begin
      op_valid_d = 1'b0;
    end

    // New instruction, may replace an operation taken in this cycle
    if (req_accept) begin
      op_valid_d          = 1'b1;
      running_d[req_id_i] = 1'b1;
    end
  end : p_sequencer

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      running_q  <= '0;
      done_q     <= '0;
      op_valid_q <= 1'b0;
    end else begin
      running_q  <= running_d;
      done_q     <= vinsn_done_i;
      op_valid_q <= op_valid_d;
    end
  end : p_ctrl_ff

  // Payload only changes on an accepted request
  always_ff @(posedge clk_i) begin : p_op_ff
    if (req_accept) begin
      op_q <= op_new;
    end
  end : p_op_ff

endmodule : lane_sequencer

`default_nettype wire

// ==== common/vfu_op_if.sv ====
// Operation handshake from the lane sequencer to the lane ALU; one instance per lane
`timescale 1ns/10ps
`default_nettype none

interface vfu_op_if import lane_pkg::*; ();

  // Operation is valid and held by the sequencer
  logic           valid;
  // ALU is idle and takes the operation
  logic           ready;
  // Decoded operation
  vfu_operation_t op;

  // Sequencer side
  modport seq (
    output valid,
    output op,
    input  ready
  );

  // ALU side
  modport alu (
    input  valid,
    input  op,
    output ready
  );

endinterface : vfu_op_if

`default_nettype wire

// ==== common/lane_pkg.sv ====
// Instruction and sequencing types shared by the lane stages, the top and the testbench
`default_nettype none

`include "lane_defs.svh"

package lane_pkg;

  import elem_pkg::*;

  // Instruction ID and one bit per ID
  typedef logic [$clog2(`NR_VINSN)-1:0] vinsn_id_t;
  typedef logic [`NR_VINSN-1:0]         vinsn_vec_t;

  // Register index and word index inside a register
  typedef logic [$clog2(`NR_VREGS)-1:0]   vreg_t;
  typedef logic [$clog2(`VREG_WORDS)-1:0] vword_idx_t;

  // Vector length, total or per lane
  typedef logic [`VL_WIDTH-1:0] vl_t;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4
  } alu_op_e;

  // Decoded operation handed from the sequencer to the ALU
  // vl here is already the lane's share
  typedef struct packed {
    vinsn_id_t id;
    alu_op_e   op;
    sew_e      sew;
    vreg_t     vs1;
    vreg_t     vs2;
    vreg_t     vd;
    vl_t       vl;
  } vfu_operation_t;

endpackage : lane_pkg

`default_nettype wire

// ==== common/elem_pkg.sv ====
// Element types of a 64-bit register word; imported by the ALU, the sequencer and the top
`default_nettype none

package elem_pkg;

  // Element width of an operation
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } sew_e;

  // One register word seen at each element width
  // Element 0 always sits in the low bits
  typedef union packed {
    logic [7:0][7:0]  b;
    logic [3:0][15:0] h;
    logic [1:0][31:0] w;
    logic [63:0]      d;
  } vword_u;

endpackage : elem_pkg

`default_nettype wire

// ==== common/lane_defs.svh ====
// Lane sizing macros; include wherever array bounds or the lane split are needed
`ifndef LANE_DEFS_SVH
`define LANE_DEFS_SVH

// Lanes in the full machine, sets how the total vl is split
`define NR_LANES 4

// In-flight instruction IDs
`define NR_VINSN 4

// Vector registers held by one lane
`define NR_VREGS 8

// 64-bit words per register in one lane
`define VREG_WORDS 4

// Width of the total vector length field
`define VL_WIDTH 8

`endif
